//--- Bender.yml
package:
  name: fuse_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lc_pkg.sv
      - fuse_ctrl_pkg.sv
      - fuse_req_if.sv
      - fuse_mem_if.sv
      - fuse_access_filter.sv
      - fuse_dai.sv
      - fuse_array.sv
      - fuse_ctrl_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_fuse_ctrl.sv

//--- fuse_access_filter.sv
`include "fuse_ctrl_macros.svh"

module fuse_access_filter
  import fuse_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  dai_cmd_e                req_cmd_i,
  input  logic [`FUSE_ADDR_W-1:0] req_addr_i,
  input  logic [`FUSE_DATA_W-1:0] req_wdata_i,
  input  logic [`FUSE_USER_W-1:0] req_user_i,
  output logic                    req_ready_o,
  fuse_req_if.filter              cmd_o
);

  logic                    valid_q;
  logic                    busy_q;
  dai_cmd_e                cmd_q;
  logic [`FUSE_ADDR_W-1:0] addr_q;
  logic [`FUSE_DATA_W-1:0] wdata_q;
  logic                    discard_q;
  logic                    accept;
  logic                    violation;

  assign req_ready_o = !busy_q && cmd_o.idle;
  assign accept      = req_valid_i && req_ready_o;

  // Partitions 0 and 1 take writes from the core user only
  assign violation = (req_cmd_i == DaiWrite) &&
                     (part_idx(req_addr_i) <= PART_IDX_W'(1)) &&
                     (req_user_i != `FUSE_CORE_USER);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      valid_q <= accept;  // One cycle only
      if (accept) begin
        busy_q <= 1'b1;
      end else if (busy_q && !valid_q && !cmd_o.idle) begin
        busy_q <= 1'b0;   // DAI back to idle after this edge
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q     <= req_cmd_i;
      addr_q    <= req_addr_i;
      wdata_q   <= req_wdata_i;
      discard_q <= violation;
    end
  end

  assign cmd_o.valid   = valid_q;
  assign cmd_o.cmd     = cmd_q;
  assign cmd_o.addr    = addr_q;
  assign cmd_o.wdata   = wdata_q;
  assign cmd_o.discard = discard_q;

  // Reads are never dropped by the policy
  a_no_read_discard: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept && req_cmd_i == DaiRead |=> !cmd_o.discard);

endmodule

//--- fuse_array.sv
`include "fuse_ctrl_macros.svh"

module fuse_array (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  fuse_mem_if.mem                 mem_i,
  input  logic                    zeroize_i,
  output logic [`FUSE_DATA_W-1:0] broadcast_o
);

  localparam int unsigned NUM_WORDS = `FUSE_NUM_PART * `FUSE_PART_WORDS;

  logic [`FUSE_DATA_W-1:0] mem_q [NUM_WORDS];
  logic [`FUSE_DATA_W-1:0] bcast_q;
  logic                    zeroized_q;

  assign mem_i.rdata = mem_q[mem_i.addr];

  // Blank fuses read as zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_i.we) begin
      mem_q[mem_i.addr] <= mem_i.wdata;
    end
  end

  //////////////////////////////////////////////////
  // Broadcast and zeroization
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      zeroized_q <= 1'b0;
      bcast_q    <= '0;
    end else if (zeroize_i || zeroized_q) begin
      zeroized_q <= 1'b1;  // Sticky
      bcast_q    <= '0;
    end else if (mem_i.we && mem_i.addr == `FUSE_BCAST_ADDR) begin
      bcast_q <= mem_i.wdata;
    end
  end

  assign broadcast_o = bcast_q;

  a_zeroize_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    zeroize_i |=> broadcast_o == '0);

endmodule

//--- fuse_ctrl_macros.svh
`ifndef FUSE_CTRL_MACROS_SVH
`define FUSE_CTRL_MACROS_SVH

// Array geometry
`define FUSE_DATA_W     32
`define FUSE_ADDR_W     6
`define FUSE_PART_WORDS 16
`define FUSE_NUM_PART   4

// Requester IDs
`define FUSE_USER_W     4
`define FUSE_CORE_USER  4'h1   // Sole writer of partitions 0 and 1

// First word of partition 2 is driven to the outside
`define FUSE_BCAST_ADDR 6'd32

`endif

//--- fuse_ctrl_pkg.sv
`include "fuse_ctrl_macros.svh"

package fuse_ctrl_pkg;
  import lc_pkg::*;

  localparam int unsigned PART_IDX_W = $clog2(`FUSE_NUM_PART);
  localparam int unsigned WORD_IDX_W = $clog2(`FUSE_PART_WORDS);

  typedef enum logic [1:0] {
    DaiRead  = 2'b00,
    DaiWrite = 2'b01
  } dai_cmd_e;

  typedef enum logic [1:0] {
    NoError     = 2'b00,
    AccessError = 2'b01,  // Recoverable, command dropped
    FatalError  = 2'b10
  } fuse_err_e;

  typedef struct packed {
    dec_lc_state_e lc_phase;   // Last phase with write access
    logic          secret;
    logic          hw_digest;
    logic          sw_digest;
  } part_info_t;

  localparam part_info_t PART_INFO [`FUSE_NUM_PART] = '{
    '{lc_phase: DecLcStTestUnlocked, secret: 1'b0, hw_digest: 1'b0, sw_digest: 1'b1}, // Test
    '{lc_phase: DecLcStDev,          secret: 1'b1, hw_digest: 1'b1, sw_digest: 1'b0}, // Manuf
    '{lc_phase: DecLcStProd,         secret: 1'b0, hw_digest: 1'b0, sw_digest: 1'b1}, // Prod
    '{lc_phase: DecLcStRma,          secret: 1'b0, hw_digest: 1'b0, sw_digest: 1'b0}  // SVN
  };

  // Partition index sits in the top address bits
  function automatic logic [PART_IDX_W-1:0] part_idx(logic [`FUSE_ADDR_W-1:0] addr);
    return addr[`FUSE_ADDR_W-1 -: PART_IDX_W];
  endfunction

  // Digest lives in the last word of a partition
  function automatic logic is_digest_word(logic [`FUSE_ADDR_W-1:0] addr);
    return addr[WORD_IDX_W-1:0] == WORD_IDX_W'(`FUSE_PART_WORDS - 1);
  endfunction

endpackage

//--- fuse_ctrl_top.sv
`include "fuse_ctrl_macros.svh"

module fuse_ctrl_top
  import lc_pkg::*;
  import fuse_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  dai_cmd_e                req_cmd_i,
  input  logic [`FUSE_ADDR_W-1:0] req_addr_i,
  input  logic [`FUSE_DATA_W-1:0] req_wdata_i,
  input  logic [`FUSE_USER_W-1:0] req_user_i,
  input  lc_state_e               lc_state_i,
  input  logic                    escalate_i,
  input  logic                    zeroize_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output fuse_err_e               rsp_err_o,
  output logic [`FUSE_DATA_W-1:0] rsp_rdata_o,
  output logic [`FUSE_DATA_W-1:0] broadcast_o,
  output logic                    fatal_o
);

  fuse_req_if req_if ();  // Filter to DAI
  fuse_mem_if mem_if ();  // DAI to array

  fuse_access_filter u_filter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_cmd_i   (req_cmd_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_user_i  (req_user_i),
    .req_ready_o (req_ready_o),
    .cmd_o       (req_if.filter)
  );

  fuse_dai u_dai (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (req_if.dai),
    .lc_state_i  (lc_state_i),
    .escalate_i  (escalate_i),
    .mem_o       (mem_if.dai),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_rdata_o (rsp_rdata_o),
    .fatal_o     (fatal_o)
  );

  fuse_array u_array (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_i       (mem_if.mem),
    .zeroize_i   (zeroize_i),
    .broadcast_o (broadcast_o)
  );

endmodule

//--- fuse_dai.sv
`include "fuse_ctrl_macros.svh"

module fuse_dai
  import lc_pkg::*;
  import fuse_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  fuse_req_if.dai                 cmd_i,
  input  lc_state_e               lc_state_i,
  input  logic                    escalate_i,
  fuse_mem_if.dai                 mem_o,
  output logic                    rsp_valid_o,
  output fuse_err_e               rsp_err_o,
  output logic [`FUSE_DATA_W-1:0] rsp_rdata_o,
  output logic                    fatal_o
);

  typedef enum logic [1:0] {IdleSt, BusySt, RespondSt, ErrorSt} dai_state_e;

  dai_state_e                state_q;
  dai_state_e                state_d;
  logic [1:0]                fat_q;     // Commands in flight during ErrorSt
  logic                      fatal_q;
  logic [`FUSE_NUM_PART-1:0] digest_q;  // Nonzero digest per partition
  fuse_err_e                 err_q;
  fuse_err_e                 dec_err;
  logic [`FUSE_DATA_W-1:0]   rdata_q;
  dec_lc_state_e             dec_lc;
  logic [PART_IDX_W-1:0]     idx;
  logic                      in_error;
  logic                      take;

  assign dec_lc   = decode_lc_state(lc_state_i);
  assign idx      = part_idx(cmd_i.addr);
  assign in_error = escalate_i || state_q == ErrorSt;
  assign take     = cmd_i.valid && !in_error &&
                    (state_q == IdleSt || state_q == RespondSt);

  //////////////////////////////////////////////////
  // Lock checks
  //////////////////////////////////////////////////

  always_comb begin
    dec_err = NoError;
    if (cmd_i.discard) begin
      dec_err = AccessError;
    end else if (cmd_i.cmd == DaiWrite) begin
      if (dec_lc > PART_INFO[idx].lc_phase || digest_q[idx]) begin
        dec_err = AccessError;  // Phase passed or digest locked
      end
    end else if (PART_INFO[idx].secret && digest_q[idx]) begin
      dec_err = AccessError;    // Secret read lock
    end
  end

  assign mem_o.addr  = cmd_i.addr;
  assign mem_o.wdata = cmd_i.wdata;
  assign mem_o.we    = take && cmd_i.cmd == DaiWrite && dec_err == NoError;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      IdleSt, RespondSt: state_d = take ? BusySt : IdleSt;
      BusySt:            state_d = RespondSt;
      default:           state_d = ErrorSt;
    endcase
    if (escalate_i) begin
      state_d = ErrorSt;  // Terminal until reset
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= IdleSt;
      fat_q    <= '0;
      fatal_q  <= 1'b0;
      digest_q <= '0;
    end else begin
      state_q <= state_d;
      fatal_q <= state_q == ErrorSt;
      if (in_error) begin
        fat_q <= {fat_q[0] || state_q == BusySt, cmd_i.valid};
      end
      // Track digest words of partitions that carry one
      if (mem_o.we && is_digest_word(cmd_i.addr) && cmd_i.wdata != '0 &&
          (PART_INFO[idx].hw_digest || PART_INFO[idx].sw_digest)) begin
        digest_q[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_error) begin
      err_q   <= FatalError;
      rdata_q <= '0;
    end else if (take) begin
      err_q   <= dec_err;
      rdata_q <= (cmd_i.cmd == DaiRead && dec_err == NoError) ? mem_o.rdata : '0;
    end
  end

  assign rsp_valid_o = state_q == RespondSt || fat_q[1];
  assign rsp_err_o   = err_q;
  assign rsp_rdata_o = rdata_q;
  assign fatal_o     = fatal_q;
  assign cmd_i.idle  = state_q == IdleSt || state_q == RespondSt ||
                       (state_q == ErrorSt && !fat_q[0]);

  // Escalation is terminal and raises the alarm a cycle later
  a_esc_terminal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    escalate_i |=> state_q == ErrorSt ##1 (state_q == ErrorSt && fatal_o));

  // No array write once the alarm is up
  a_no_fatal_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fatal_o |-> !mem_o.we);

endmodule

//--- fuse_mem_if.sv
`include "fuse_ctrl_macros.svh"

interface fuse_mem_if ();

  logic                    we;
  logic [`FUSE_ADDR_W-1:0] addr;
  logic [`FUSE_DATA_W-1:0] wdata;
  logic [`FUSE_DATA_W-1:0] rdata;  // Combinational from addr

  modport dai (
    output we, addr, wdata,
    input  rdata
  );

  modport mem (
    input  we, addr, wdata,
    output rdata
  );

endinterface

//--- fuse_req_if.sv
`include "fuse_ctrl_macros.svh"

interface fuse_req_if
  import fuse_ctrl_pkg::*;
();

  logic                    valid;    // Single-cycle command strobe
  dai_cmd_e                cmd;
  logic [`FUSE_ADDR_W-1:0] addr;
  logic [`FUSE_DATA_W-1:0] wdata;
  logic                    discard;  // Policy violation flagged upstream
  logic                    idle;     // DAI can take a command

  modport filter (
    output valid, cmd, addr, wdata, discard,
    input  idle
  );

  modport dai (
    input  valid, cmd, addr, wdata, discard,
    output idle
  );

endinterface

//--- lc_pkg.sv
package lc_pkg;

  // Encoded state as delivered by the life-cycle controller
  typedef enum logic [15:0] {
    LcStRaw          = 16'h0000,
    LcStTestUnlocked = 16'h3a5c,
    LcStDev          = 16'h5e21,
    LcStProd         = 16'h96b4,
    LcStProdEnd      = 16'hc3d8,
    LcStRma          = 16'he70f
  } lc_state_e;

  // Ordered so that later phases compare greater
  typedef enum logic [2:0] {
    DecLcStRaw,
    DecLcStTestUnlocked,
    DecLcStDev,
    DecLcStProd,
    DecLcStProdEnd,
    DecLcStRma,
    DecLcStScrap
  } dec_lc_state_e;

  function automatic dec_lc_state_e decode_lc_state(lc_state_e lc_state);
    dec_lc_state_e dec;
    case (lc_state)
      LcStRaw:          dec = DecLcStRaw;
      LcStTestUnlocked: dec = DecLcStTestUnlocked;
      LcStDev:          dec = DecLcStDev;
      LcStProd:         dec = DecLcStProd;
      LcStProdEnd:      dec = DecLcStProdEnd;
      LcStRma:          dec = DecLcStRma;
      default:          dec = DecLcStScrap;  // Unknown encodings end up here
    endcase
    return dec;
  endfunction

endpackage

//--- tb_fuse_ctrl.sv
`include "fuse_ctrl_macros.svh"

module tb_fuse_ctrl
  import lc_pkg::*;
  import fuse_ctrl_pkg::*;
();

  localparam int CYCLE    = 20;
  localparam int NUM_CMDS = 34;  // Commands issued below
  localparam logic [`FUSE_USER_W-1:0] OTHER_USER = 4'h5;
  localparam int PHASE_RANK [`FUSE_NUM_PART] = '{1, 2, 3, 5};  // Last phase with write access

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    req_valid;
  dai_cmd_e                req_cmd;
  logic [`FUSE_ADDR_W-1:0] req_addr;
  logic [`FUSE_DATA_W-1:0] req_wdata;
  logic [`FUSE_USER_W-1:0] req_user;
  lc_state_e               lc_state;
  logic                    escalate;
  logic                    zeroize;
  logic                    req_ready_o;
  logic                    rsp_valid_o;
  fuse_err_e               rsp_err_o;
  logic [`FUSE_DATA_W-1:0] rsp_rdata_o;
  logic [`FUSE_DATA_W-1:0] broadcast_o;
  logic                    fatal_o;

  // Reference model state
  logic [`FUSE_DATA_W-1:0]   shadow [`FUSE_NUM_PART * `FUSE_PART_WORDS];
  logic [`FUSE_NUM_PART-1:0] locked;  // Nonzero digest seen
  fuse_err_e                 exp_err;
  logic [`FUSE_DATA_W-1:0]   exp_rdata;
  logic [`FUSE_DATA_W-1:0]   exp_bcast;
  logic                      zeroized;
  logic                      escalated;
  integer                    seed = 32'hc8a2_fdd5;

  fuse_ctrl_top UUT (
    .clk_i (clk), .rst_n_i (rst_n), .req_valid_i (req_valid), .req_cmd_i (req_cmd),
    .req_addr_i (req_addr), .req_wdata_i (req_wdata), .req_user_i (req_user),
    .lc_state_i (lc_state), .escalate_i (escalate), .zeroize_i (zeroize),
    .req_ready_o (req_ready_o), .rsp_valid_o (rsp_valid_o), .rsp_err_o (rsp_err_o),
    .rsp_rdata_o (rsp_rdata_o), .broadcast_o (broadcast_o), .fatal_o (fatal_o)
  );

  always #(CYCLE / 2) clk = ~clk;

  task automatic stop_with_failure(input string detail);
    $display("TESTBENCH FAILED");
    $display("%s", detail);
    $fatal(1);
  endtask

  function automatic int lc_rank(lc_state_e lc);
    case (lc)
      LcStRaw:          return 0;
      LcStTestUnlocked: return 1;
      LcStDev:          return 2;
      LcStProd:         return 3;
      LcStProdEnd:      return 4;
      LcStRma:          return 5;
      default:          return 6;  // Scrap
    endcase
  endfunction

  function automatic fuse_err_e predict_err(dai_cmd_e cmd, logic [`FUSE_ADDR_W-1:0] addr,
                                            logic [`FUSE_USER_W-1:0] user);
    int part;
    part = addr / `FUSE_PART_WORDS;
    if (escalated) return FatalError;
    if (cmd == DaiWrite) begin
      if (part < 2 && user != `FUSE_CORE_USER) return AccessError;
      if (lc_rank(lc_state) > PHASE_RANK[part] || locked[part]) return AccessError;
    end else if (part == 1 && locked[part]) begin
      return AccessError;  // Secret partition
    end
    return NoError;
  endfunction

  //////////////////////////////////////////////////
  // Command driver
  //////////////////////////////////////////////////

  task automatic issue_cmd(input dai_cmd_e cmd, input logic [`FUSE_ADDR_W-1:0] addr,
                           input logic [`FUSE_USER_W-1:0] user,
                           input logic esc_in_flight = 1'b0);
    logic [`FUSE_DATA_W-1:0] data;
    int                      part;
    logic                    digest;
    data   = $random(seed);
    part   = addr / `FUSE_PART_WORDS;
    digest = (addr % `FUSE_PART_WORDS) == `FUSE_PART_WORDS - 1;
    if (digest) data = data | 32'h1;  // Digest writes must lock
    exp_err   = predict_err(cmd, addr, user);
    exp_rdata = (cmd == DaiRead && exp_err == NoError) ? shadow[addr] : '0;
    req_cmd   = cmd;
    req_addr  = addr;
    req_wdata = data;
    req_user  = user;
    req_valid = 1'b1;
    while (!req_ready_o) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // Accepted at this edge
    #1;
    req_valid = 1'b0;
    if (esc_in_flight) begin
      escalate  = 1'b1;
      escalated = 1'b1;
      exp_err   = FatalError;
      exp_rdata = '0;
    end else if (cmd == DaiWrite && exp_err == NoError) begin
      shadow[addr] = data;
      if (digest && part != 3) locked[part] = 1'b1;
      if (addr == `FUSE_BCAST_ADDR && !zeroized) exp_bcast = data;
    end
    do begin
      @(posedge clk);
      #1;
      escalate = 1'b0;
    end while (!rsp_valid_o);
    @(posedge clk);  // Response sampled by the checks here
    #1;
  endtask

  task automatic pulse_zeroize();
    zeroize = 1'b1;
    @(posedge clk);
    #1;
    zeroize   = 1'b0;
    zeroized  = 1'b1;
    exp_bcast = '0;
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready_o |=> !rsp_valid_o ##1 !rsp_valid_o ##1 rsp_valid_o ##1 !rsp_valid_o)
    else stop_with_failure("Response did not come exactly 2 cycles after acceptance");
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready_o |=> !req_ready_o ##1 !req_ready_o ##1 req_ready_o)
    else stop_with_failure("Ready did not stay low until the response");
  a_err: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> rsp_err_o == exp_err)
    else stop_with_failure($sformatf("Fail rsp_err_o: got %h, expected %h",
                                     $sampled(rsp_err_o), $sampled(exp_err)));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> rsp_rdata_o == exp_rdata)
    else stop_with_failure($sformatf("Fail rsp_rdata_o: got %h, expected %h",
                                     $sampled(rsp_rdata_o), $sampled(exp_rdata)));
  a_bcast: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> broadcast_o == exp_bcast)
    else stop_with_failure($sformatf("Fail broadcast_o: got %h, expected %h",
                                     $sampled(broadcast_o), $sampled(exp_bcast)));
  a_zeroized: assert property (@(posedge clk) disable iff (!rst_n)
    zeroized |-> broadcast_o == '0)
    else stop_with_failure($sformatf("Fail broadcast_o: got %h, expected 0",
                                     $sampled(broadcast_o)));
  a_fatal_rise: assert property (@(posedge clk) disable iff (!rst_n)
    escalate |-> ##2 fatal_o)
    else stop_with_failure($sformatf("Fail fatal_o: got %h, expected 1", $sampled(fatal_o)));
  a_fatal_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fatal_o |=> fatal_o)
    else stop_with_failure("Fatal output dropped after it was set");
  a_fatal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !escalated |-> !fatal_o)
    else stop_with_failure($sformatf("Fail fatal_o: got %h, expected 0", $sampled(fatal_o)));

  initial begin
    #((NUM_CMDS * 10 + 100) * CYCLE);
    stop_with_failure("Watchdog expired before the test sequence finished");
  end

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_cmd   = DaiRead;
    req_addr  = '0;
    req_wdata = '0;
    req_user  = `FUSE_CORE_USER;
    lc_state  = LcStRaw;
    escalate  = 1'b0;
    zeroize   = 1'b0;
    locked    = '0;
    exp_err   = NoError;
    exp_rdata = '0;
    exp_bcast = '0;
    zeroized  = 1'b0;
    escalated = 1'b0;
    for (int i = 0; i < `FUSE_NUM_PART * `FUSE_PART_WORDS; i++) shadow[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    a_reset_values: assert (req_ready_o && !rsp_valid_o && !fatal_o && broadcast_o == '0)
      else stop_with_failure("Outputs not at their reset values");

    for (int p = 0; p < `FUSE_NUM_PART; p++) begin  // Raw state, core user
      issue_cmd(DaiWrite, 6'(p * `FUSE_PART_WORDS + 2), `FUSE_CORE_USER);
      issue_cmd(DaiRead, 6'(p * `FUSE_PART_WORDS + 2), `FUSE_CORE_USER);
    end
    issue_cmd(DaiWrite, 6'd2, OTHER_USER);   // User policy
    issue_cmd(DaiRead, 6'd2, OTHER_USER);
    issue_cmd(DaiWrite, 6'd18, OTHER_USER);
    issue_cmd(DaiWrite, 6'd34, OTHER_USER);
    issue_cmd(DaiRead, 6'd34, OTHER_USER);
    issue_cmd(DaiWrite, `FUSE_BCAST_ADDR, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd31, `FUSE_CORE_USER);  // Secret partition digest
    issue_cmd(DaiRead, 6'd18, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd19, `FUSE_CORE_USER);
    issue_cmd(DaiRead, 6'd34, `FUSE_CORE_USER);

    lc_state = LcStProd;
    issue_cmd(DaiWrite, 6'd3, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd20, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd40, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd50, `FUSE_CORE_USER);
    issue_cmd(DaiRead, 6'd50, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, `FUSE_BCAST_ADDR, `FUSE_CORE_USER);
    pulse_zeroize();
    issue_cmd(DaiWrite, `FUSE_BCAST_ADDR, `FUSE_CORE_USER);  // Broadcast stays zero
    issue_cmd(DaiRead, `FUSE_BCAST_ADDR, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd47, `FUSE_CORE_USER);  // Production digest
    issue_cmd(DaiWrite, 6'd40, `FUSE_CORE_USER);
    issue_cmd(DaiRead, 6'd40, `FUSE_CORE_USER);

    lc_state = lc_state_e'(16'h1234);  // Unknown encoding decodes as scrap
    issue_cmd(DaiWrite, 6'd51, `FUSE_CORE_USER);

    lc_state = LcStProd;
    issue_cmd(DaiWrite, 6'd52, `FUSE_CORE_USER, 1'b1);  // Escalation while in flight
    issue_cmd(DaiRead, 6'd52, `FUSE_CORE_USER);
    issue_cmd(DaiWrite, 6'd53, `FUSE_CORE_USER);
    issue_cmd(DaiRead, 6'd2, `FUSE_CORE_USER);

    repeat (4) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
lc_pkg.sv
fuse_ctrl_pkg.sv
fuse_req_if.sv
fuse_mem_if.sv
fuse_access_filter.sv
fuse_dai.sv
fuse_array.sv
fuse_ctrl_top.sv
tb_fuse_ctrl.sv
